//--- hdl/cpu_settings.svh
// Width, register file size and fetch address macros for the CPU
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define XLEN 32
`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch address and byte step between instructions
`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4

`endif

//--- hdl/cpuPkg.sv
// CPU package with opcode and ALU enums, stage payload structs and the bubble function
`include "cpu_settings.svh"

package cpuPkg;

	// Opcode in instr[31:26]
	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_SLT  = 6'd6,
		OP_ADDI = 6'd7,
		OP_BEQ  = 6'd8,
		OP_HALT = 6'd9
	} opcodeT;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} aluOpT;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic valid;
		aluOpT aluOp;
		logic useImm;
		logic isBranch;
		logic isHalt;
		logic writeEn;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`XLEN-1:0] srcA;
		logic [`XLEN-1:0] srcB;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] pc;
	} idExT;

	typedef struct packed {
		logic writeEn;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] result;
	} exWbT;

	// Wide enough for the largest stage payload
	localparam int BUBBLE_W = $bits(idExT);

	function automatic logic [BUBBLE_W-1:0] bubble();
		return '0;
	endfunction

endpackage

//--- hdl/stageReg.sv
// Pipeline stage register with enable and flush to bubble
module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    en,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);
	import cpuPkg::*;

	localparam payloadT EMPTY = payloadT'(bubble());

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= EMPTY;
		end else if (en) begin
			// A flushed slot turns into a bubble
			q <= flush ? EMPTY : d;
		end
	end

	// Control inputs come from the execute stage and must be resolved
	stageCtrlKnown: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({flush, en}));

endmodule

//--- hdl/fetchStage.sv
// Fetch stage with the program counter, branch redirect and halt freeze
`include "cpu_settings.svh"

module fetchStage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`XLEN-1:0]     instrData,
	input  logic                 redirect,
	input  logic [`XLEN-1:0]     redirectPc,
	input  logic                 halted,
	output logic [`XLEN-1:0]     instrAddr,
	output cpuPkg::ifIdT         ifId
);
	import cpuPkg::*;

	logic [`XLEN-1:0] pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else if (!halted) begin
			pc <= redirect ? redirectPc : pc + `PC_STEP;
		end
	end

	assign instrAddr = pc;

	// Instruction memory answers in the same cycle
	always_comb begin
		ifId.valid = 1'b1;
		ifId.pc = pc;
		ifId.instr = instrData;
	end

	// Execute stops redirecting once the machine is frozen
	noRedirectHalted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !redirect);

endmodule

//--- hdl/decodeStage.sv
// Decode stage with instruction decoder and write-through register file
`include "cpu_settings.svh"

module decodeStage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  cpuPkg::ifIdT            ifId,
	input  logic                    wbEn,
	input  logic [`REG_ADDR_W-1:0]  wbAddr,
	input  logic [`XLEN-1:0]        wbData,
	output cpuPkg::idExT            idEx
);
	import cpuPkg::*;

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic [`REG_ADDR_W-1:0] rsIdx;
	logic [`REG_ADDR_W-1:0] rtIdx;
	logic [5:0] opcode;

	// Same-cycle write is visible to the read
	function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] idx);
		if (idx == '0)
			return '0;
		if (wbEn && wbAddr == idx)
			return wbData;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbEn && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	assign opcode = ifId.instr[31:26];

	// BEQ compares the registers in 25..21 and 20..16, imm keeps 15..0
	always_comb begin
		if (opcode == OP_BEQ) begin
			rsIdx = ifId.instr[25:21];
			rtIdx = ifId.instr[20:16];
		end else begin
			rsIdx = ifId.instr[20:16];
			rtIdx = ifId.instr[15:11];
		end
	end

	always_comb begin
		idEx = '0;
		idEx.valid = ifId.valid;
		idEx.rd = ifId.instr[25:21];
		idEx.rs = rsIdx;
		idEx.rt = rtIdx;
		idEx.srcA = readReg(rsIdx);
		idEx.srcB = readReg(rtIdx);
		idEx.imm = {{(`XLEN-16){ifId.instr[15]}}, ifId.instr[15:0]};
		idEx.pc = ifId.pc;
		idEx.aluOp = ALU_ADD;
		case (opcode)
			OP_ADD: idEx.writeEn = 1'b1;
			OP_SUB: begin
				idEx.aluOp = ALU_SUB;
				idEx.writeEn = 1'b1;
			end
			OP_AND: begin
				idEx.aluOp = ALU_AND;
				idEx.writeEn = 1'b1;
			end
			OP_OR: begin
				idEx.aluOp = ALU_OR;
				idEx.writeEn = 1'b1;
			end
			OP_XOR: begin
				idEx.aluOp = ALU_XOR;
				idEx.writeEn = 1'b1;
			end
			OP_SLT: begin
				idEx.aluOp = ALU_SLT;
				idEx.writeEn = 1'b1;
			end
			OP_ADDI: begin
				idEx.useImm = 1'b1;
				idEx.writeEn = 1'b1;
			end
			OP_BEQ: begin
				idEx.isBranch = 1'b1;
				idEx.rd = '0;
			end
			OP_HALT: idEx.isHalt = 1'b1;
			// NOP and unknown opcodes write nothing
			default: idEx.rd = '0;
		endcase
	end

	// Register 0 stays zero across every write port access
	reg0Zero: assert property (@(posedge clk) disable iff (!rst_n)
		regs[0] == '0);

endmodule

//--- hdl/executeStage.sv
// Execute stage with operand forwarding, ALU, BEQ resolve and halt detection
`include "cpu_settings.svh"

module executeStage (
	input  cpuPkg::idExT            idEx,
	input  logic                    fwdEn,
	input  logic [`REG_ADDR_W-1:0]  fwdAddr,
	input  logic [`XLEN-1:0]        fwdData,
	input  logic                    clk,
	input  logic                    rst_n,
	output cpuPkg::exWbT            exWb,
	output logic                    redirect,
	output logic [`XLEN-1:0]        redirectPc,
	output logic                    halted
);
	import cpuPkg::*;

	logic fwdA;
	logic fwdB;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] result;

	// Previous result overrides the register file read
	assign fwdA = fwdEn && fwdAddr != '0 && fwdAddr == idEx.rs;
	assign fwdB = fwdEn && fwdAddr != '0 && fwdAddr == idEx.rt;
	assign opA = fwdA ? fwdData : idEx.srcA;
	assign opB = fwdB ? fwdData : idEx.srcB;
	assign aluB = idEx.useImm ? idEx.imm : opB;

	always_comb begin
		case (idEx.aluOp)
			ALU_ADD: result = opA + aluB;
			ALU_SUB: result = opA - aluB;
			ALU_AND: result = opA & aluB;
			ALU_OR:  result = opA | aluB;
			ALU_XOR: result = opA ^ aluB;
			ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: result = '0;
		endcase
	end

	always_comb begin
		exWb.writeEn = idEx.valid && idEx.writeEn;
		exWb.rd = idEx.rd;
		exWb.result = result;
	end

	// Frozen idEx may still hold a younger BEQ
	assign redirect = idEx.valid && idEx.isBranch && opA == opB && !halted;
	assign redirectPc = idEx.pc + `PC_STEP + {idEx.imm[`XLEN-3:0], 2'b00};

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (idEx.valid && idEx.isHalt) begin
			halted <= 1'b1;
		end
	end

	// Flush of idEx leaves a bubble behind a taken branch
	redirectIsBranch: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |-> (idEx.valid && idEx.isBranch) ##1 !redirect);

endmodule

//--- hdl/cpuTop.sv
// CPU top level connecting fetch, decode, execute and the stage registers
`include "cpu_settings.svh"

module cpuTop (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`XLEN-1:0]        instrData,
	output logic [`XLEN-1:0]        instrAddr,
	output logic                    wbEn,
	output logic [`REG_ADDR_W-1:0]  wbAddr,
	output logic [`XLEN-1:0]        wbData,
	output logic                    halt
);
	import cpuPkg::*;

	ifIdT fetchPayload;
	ifIdT decodeIn;
	idExT decodePayload;
	idExT executeIn;
	exWbT executePayload;
	exWbT wbPayload;

	logic redirect;
	logic [`XLEN-1:0] redirectPc;
	logic halted;
	logic stageEn;

	// Halt freezes every stage register
	assign stageEn = !halted;

	fetchStage fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.instrData  (instrData),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.halted     (halted),
		.instrAddr  (instrAddr),
		.ifId       (fetchPayload)
	);

	stageReg #(.payloadT(ifIdT)) ifId (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (stageEn),
		.flush (redirect),
		.d     (fetchPayload),
		.q     (decodeIn)
	);

	decodeStage decode (
		.clk    (clk),
		.rst_n  (rst_n),
		.ifId   (decodeIn),
		.wbEn   (wbPayload.writeEn),
		.wbAddr (wbPayload.rd),
		.wbData (wbPayload.result),
		.idEx   (decodePayload)
	);

	stageReg #(.payloadT(idExT)) idEx (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (stageEn),
		.flush (redirect),
		.d     (decodePayload),
		.q     (executeIn)
	);

	executeStage execute (
		.idEx       (executeIn),
		.fwdEn      (wbPayload.writeEn),
		.fwdAddr    (wbPayload.rd),
		.fwdData    (wbPayload.result),
		.clk        (clk),
		.rst_n      (rst_n),
		.exWb       (executePayload),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.halted     (halted)
	);

	// The BEQ itself moves on, only younger stages flush
	stageReg #(.payloadT(exWbT)) exWb (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (stageEn),
		.flush (1'b0),
		.d     (executePayload),
		.q     (wbPayload)
	);

	assign wbEn = wbPayload.writeEn;
	assign wbAddr = wbPayload.rd;
	assign wbData = wbPayload.result;
	assign halt = halted;

endmodule

//--- dv/tbClock.sv
// Testbench clock and reset generator
module tbClock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Low for four rising edges, released just after the last one
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- dv/cpuTb.sv
// CPU testbench with program ROM, reference model, assertions and timeout
`include "cpu_settings.svh"

module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpuPkg::*;

	localparam int ROM_WORDS = 64;
	localparam int RANDOM_COUNT = 30;

	logic clk;
	logic rst_n;
	logic [`XLEN-1:0] instrData;
	logic [`XLEN-1:0] instrAddr;
	logic wbEn;
	logic [`REG_ADDR_W-1:0] wbAddr;
	logic [`XLEN-1:0] wbData;
	logic halt;

	logic [`XLEN-1:0] rom [ROM_WORDS];
	int progLen = 0;

	// Reference results
	logic [`REG_ADDR_W-1:0] expAddr [ROM_WORDS];
	logic [`XLEN-1:0] expData [ROM_WORDS];
	int expCount = 0;
	int expIdx;
	logic takenAt [ROM_WORDS];
	logic [`XLEN-1:0] targetAt [ROM_WORDS];
	logic [`XLEN-1:0] haltPc;

	// Fetch addresses of the last three cycles
	logic [`XLEN-1:0] addrHist [3];
	logic oldTaken;
	logic [`XLEN-1:0] oldTarget;

	int cycles = 0;
	int cycleLimit = 0;

	tbClock clockGen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	cpuTop uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.instrData (instrData),
		.instrAddr (instrAddr),
		.wbEn      (wbEn),
		.wbAddr    (wbAddr),
		.wbData    (wbData),
		.halt      (halt)
	);

	// Combinational instruction memory with NOP outside the program area
	always_comb begin
		if (instrAddr < 4 * ROM_WORDS)
			instrData = rom[instrAddr[7:2]];
		else
			instrData = '0;
	end

	function automatic logic [`XLEN-1:0] regOp(opcodeT op, int rd, int rs, int rt);
		return {op, 5'(rd), 5'(rs), 5'(rt), 11'b0};
	endfunction

	// ADDI, BEQ and HALT share this layout
	function automatic logic [`XLEN-1:0] immOp(opcodeT op, int ra, int rb, int imm);
		return {op, 5'(ra), 5'(rb), 16'(imm)};
	endfunction

	function automatic logic [`XLEN-1:0] aluValue(opcodeT op, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b, logic [`XLEN-1:0] imm);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SLT: return ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
			default: return a + imm;
		endcase
	endfunction

	task automatic stopWithFailure(string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(string name, logic [`XLEN-1:0] expected,
			logic [`XLEN-1:0] actual);
		stopWithFailure($sformatf("CHECK FAILED %s expected %h got %h", name, expected, actual));
	endtask

	task automatic emit(logic [`XLEN-1:0] instr);
		rom[progLen] = instr;
		progLen++;
	endtask

	task automatic buildProgram();
		int kind;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		// Dependent chain followed by a write to r0 and a read of it
		emit(immOp(OP_ADDI, 1, 0, 'h1234));
		emit(immOp(OP_ADDI, 2, 1, -7));
		emit(regOp(OP_ADD, 3, 1, 2));
		emit(regOp(OP_SUB, 4, 3, 1));
		emit(regOp(OP_AND, 5, 4, 3));
		emit(immOp(OP_ADDI, 0, 1, 5));
		emit(regOp(OP_OR, 5, 0, 2));
		// Taken branch over two writes and one that falls through
		emit(immOp(OP_BEQ, 1, 1, 2));
		emit(immOp(OP_ADDI, 6, 0, 'h77));
		emit(immOp(OP_ADDI, 7, 0, 'h88));
		emit(immOp(OP_BEQ, 1, 2, 2));
		emit(regOp(OP_SLT, 6, 2, 1));
		emit(regOp(OP_XOR, 7, 6, 5));
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			kind = $urandom_range(9, 0);
			if (kind < 6)
				emit(regOp(opcodeT'(int'(OP_ADD) + kind), $urandom_range(7, 0),
					$urandom_range(7, 0), $urandom_range(7, 0)));
			else if (kind < 8)
				emit(immOp(OP_ADDI, $urandom_range(7, 0), $urandom_range(7, 0),
					$urandom_range(16'hffff, 0)));
			else
				emit(immOp(OP_BEQ, $urandom_range(3, 0), $urandom_range(3, 0), 2));
		end
		// Two plain ops so no branch shadow covers HALT
		emit(immOp(OP_ADDI, 2, 3, 1));
		emit(regOp(OP_ADD, 4, 2, 3));
		emit(immOp(OP_HALT, 0, 0, 0));
		emit(immOp(OP_ADDI, 6, 0, 'h55));
		emit(regOp(OP_ADD, 7, 6, 6));
	endtask

	// In-order model of the program
	task automatic runReference();
		logic [`XLEN-1:0] regs [`REG_COUNT];
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] target;
		opcodeT op;
		int pc;
		bit done;
		for (int i = 0; i < `REG_COUNT; i++)
			regs[i] = '0;
		for (int i = 0; i < ROM_WORDS; i++) begin
			takenAt[i] = 1'b0;
			targetAt[i] = '0;
		end
		pc = 0;
		done = 1'b0;
		while (!done && pc < progLen) begin
			instr = rom[pc];
			op = opcodeT'(instr[31:26]);
			imm = `XLEN'($signed(instr[15:0]));
			if (op >= OP_ADD && op <= OP_ADDI) begin
				expAddr[expCount] = instr[25:21];
				expData[expCount] = aluValue(op, regs[instr[20:16]], regs[instr[15:11]], imm);
				if (instr[25:21] != 0)
					regs[instr[25:21]] = expData[expCount];
				expCount++;
				pc++;
			end else if (op == OP_BEQ) begin
				target = 4 * pc + 4 + 4 * imm;
				if (regs[instr[25:21]] == regs[instr[20:16]]) begin
					takenAt[pc] = 1'b1;
					targetAt[pc] = target;
					pc = int'(target >> 2);
				end else begin
					pc++;
				end
			end else if (op == OP_HALT) begin
				haltPc = 4 * pc;
				done = 1'b1;
			end else begin
				pc++;
			end
		end
	endtask

	always_ff @(posedge clk) begin
		if (!rst_n)
			expIdx <= 0;
		else if (wbEn)
			expIdx <= expIdx + 1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++)
				addrHist[i] <= `RESET_PC;
		end else begin
			addrHist[0] <= instrAddr;
			addrHist[1] <= addrHist[0];
			addrHist[2] <= addrHist[1];
		end
	end

	// Instruction fetched three cycles ago has just left execute
	assign oldTaken = takenAt[addrHist[2][7:2]];
	assign oldTarget = targetAt[addrHist[2][7:2]];

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit)
			stopWithFailure("Timeout: the program never halted");
	end

	resetState: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rst_n) |-> (instrAddr == `RESET_PC && !halt && !wbEn)
			##1 !wbEn ##1 !wbEn ##1 wbEn)
		else stopWithFailure("Reset state or first retire timing is wrong");

	noExtraWrite: assert property (@(posedge clk) disable iff (!rst_n)
		wbEn |-> expIdx < expCount)
		else stopWithFailure("A write retired that the program never makes");

	wbAddrMatch: assert property (@(posedge clk) disable iff (!rst_n)
		wbEn |-> wbAddr == expAddr[expIdx])
		else reportMismatch("wbAddr", `XLEN'(expAddr[$sampled(expIdx)]),
			`XLEN'($sampled(wbAddr)));

	wbDataMatch: assert property (@(posedge clk) disable iff (!rst_n)
		wbEn |-> wbData == expData[expIdx])
		else reportMismatch("wbData", expData[$sampled(expIdx)], $sampled(wbData));

	fetchStep: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && !$past(halt) && !oldTaken |-> instrAddr == addrHist[0] + `PC_STEP)
		else reportMismatch("instrAddr", $sampled(addrHist[0]) + `PC_STEP, $sampled(instrAddr));

	branchRedirect: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && !$past(halt) && oldTaken |-> instrAddr == oldTarget)
		else reportMismatch("instrAddr", $sampled(oldTarget), $sampled(instrAddr));

	haltOnTime: assert property (@(posedge clk) disable iff (!rst_n)
		addrHist[2] == haltPc |-> halt)
		else stopWithFailure("halt did not rise after HALT left execute");

	haltSticky: assert property (@(posedge clk) disable iff (!rst_n)
		halt |=> halt)
		else stopWithFailure("halt dropped while the machine was frozen");

	haltFreeze: assert property (@(posedge clk) disable iff (!rst_n)
		$past(halt) |-> instrAddr == addrHist[0])
		else reportMismatch("instrAddr", $sampled(addrHist[0]), $sampled(instrAddr));

	haltQuiet: assert property (@(posedge clk) disable iff (!rst_n)
		halt |-> !wbEn)
		else stopWithFailure("A write retired while halted");

	lastWriteBeforeHalt: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(halt) |-> expIdx == expCount)
		else stopWithFailure("halt rose before every older write had retired");

	initial begin
		void'($urandom(89));
		buildProgram();
		runReference();
		cycleLimit = 4 * progLen + 50;
		wait (rst_n === 1'b1);
		wait (halt === 1'b1);
		// A few frozen cycles for the halt checks
		repeat (4) @(posedge clk);
		if (expIdx == expCount) begin
			$display("No errors");
			$finish;
		end else begin
			stopWithFailure("Not every expected write retired");
		end
	end

endmodule

//--- build.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/stageReg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/cpuTop.sv
dv/tbClock.sv
dv/cpuTb.sv

//--- Bender.yml
package:
  name: cpu_pipeline

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpuPkg.sv
      - hdl/stageReg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/executeStage.sv
      - hdl/cpuTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tbClock.sv
      - dv/cpuTb.sv
